/* Bender.yml */
package:
  name: wb_slave_fabric

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/wbfab_pkg.sv
      - hw/wb_addr_decode.sv
      - hw/scratch_ram_port.sv
      - hw/wb_resp_merge.sv
      - hw/wb_slave_fabric.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/wb_slave_fabric_asserts.sv
      - dv/wb_slave_fabric_tb.sv

/* dv/wb_slave_fabric_asserts.sv */
// Protocol assertions on the fabric's master side
// Bound into the top level, watches the response pulses and stall

`timescale 1ns/1ps

module wb_slave_fabric_asserts (
	input  logic	i_clk,
	input  logic	i_reset,
	input  logic	i_stall,
	input  logic	i_ack,
	input  logic	i_err
);

	// Read by the testbench at the end of the run
	int fail_count = 0;

	////////////////////////////////////////////////////////////
	// Response pulses
	////////////////////////////////////////////////////////////

	// A request ends in either an ack or an error, never both
	a_ack_err_excl: assert property (@(posedge i_clk) disable iff (i_reset)
		!(i_ack && i_err))
	else
	begin
		fail_count++;
		$error("o_ack and o_err high in the same cycle");
	end

	// Nothing can have reached a slave yet
	a_quiet_after_reset: assert property (@(posedge i_clk)
		$fell(i_reset) |-> !(i_ack || i_err) [*2])
	else
	begin
		fail_count++;
		$error("response pulse within two cycles of reset release");
	end

	// Decoder register is empty during reset
	a_no_stall_in_reset: assert property (@(posedge i_clk)
		i_reset ##1 i_reset |-> !i_stall)
	else
	begin
		fail_count++;
		$error("o_stall high while reset is held");
	end

endmodule

/* dv/wb_slave_fabric_tb.sv */
// Testbench for the Wishbone slave fabric
// Random requests against a reference memory, responses checked in order

`timescale 1ns/1ps

`include "wbfab_macros.svh"

module wb_slave_fabric_tb;

	localparam int N_REQ       = 2000;
	localparam int CLK_PERIOD  = 8;
	// Decoder register, then slave register: master samples two edges after acceptance
	localparam int RSP_LATENCY = 2;
	// Four cycles per request is far above the average with gaps and stalls
	localparam int WATCHDOG_NS = N_REQ * 4 * CLK_PERIOD + 2000;
	// Only a few requests in flight, each done within a few cycles
	localparam int DRAIN_CYCLES = 16;
	localparam int MAP_WORDS   = `WBFAB_NS * `WBFAB_MEM_WORDS;

	// One expected response, queued in acceptance order
	typedef struct packed {
		logic			err;
		logic			rd;
		logic			isolated;
		logic [`WBFAB_DW-1:0]	data;
		logic [31:0]		cyc;
	} exp_rsp_t;

	logic			i_clk = 1'b0;
	logic			i_reset;
	logic			i_valid;
	wbfab_pkg::wb_req_t	i_req;
	logic			o_stall;
	logic			o_ack;
	logic			o_err;
	logic [`WBFAB_DW-1:0]	o_rdata;

	// Reference memory over the whole mapped range
	logic [`WBFAB_DW-1:0]	model_mem [0:MAP_WORDS-1];
	exp_rsp_t		exp_q [$];
	integer			seed;
	int			cyc = 0;
	int			sent = 0;
	int			rsp_count = 0;
	int			bp_hits = 0;
	int			iso_hits = 0;
	logic			holding;
	// Last two accepted requests, for the back-pressure check
	int			last_cyc = -10;
	int			last_slave = 0;
	logic			last_mapped = 1'b0;
	logic			last_wr = 1'b0;
	int			prev_cyc = -10;
	int			prev_slave = 0;
	logic			prev_wr = 1'b0;

	always #(CLK_PERIOD/2) i_clk = ~i_clk;

	// Counts rising edges, read on falling edges
	always @(posedge i_clk)
		cyc <= cyc + 1;

	wb_slave_fabric i_wb_slave_fabric (
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.i_valid (i_valid),
		.i_req   (i_req),
		.o_stall (o_stall),
		.o_ack   (o_ack),
		.o_err   (o_err),
		.o_rdata (o_rdata)
	);

	bind wb_slave_fabric wb_slave_fabric_asserts i_protocol_asserts (
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.i_stall (o_stall),
		.i_ack   (o_ack),
		.i_err   (o_err)
	);

	////////////////////////////////////////////////////////////
	// Failure reporting
	////////////////////////////////////////////////////////////

	task automatic abort_run();
		$display("Done: errors found");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
		$display("** Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
		abort_run();
	endtask

	////////////////////////////////////////////////////////////
	// Response side
	////////////////////////////////////////////////////////////

	// Pops the oldest expected entry on every ack or err
	task automatic check_response();
		exp_rsp_t e;
		if (o_ack || o_err)
		begin
			assert (exp_q.size() > 0)
			else
			begin
				$display("Error at %0t ns: response seen with no request outstanding", $time);
				abort_run();
			end
			e = exp_q.pop_front();
			rsp_count++;
			// Unmapped must give err and never ack
			assert (o_err == e.err) else report_mismatch("o_err", o_err, e.err);
			assert (o_ack == !e.err) else report_mismatch("o_ack", o_ack, !e.err);
			if (e.rd)
				assert (o_rdata == e.data) else report_mismatch("o_rdata", o_rdata, e.data);
			// Master samples the pulse at the coming rising edge
			if (e.isolated)
				assert (cyc + 1 - int'(e.cyc) == RSP_LATENCY)
				else report_mismatch("response latency", cyc + 1 - int'(e.cyc), RSP_LATENCY);
		end
	endtask

	// Request right behind a write to the same slave must be held
	task automatic check_back_pressure();
		if (last_cyc == cyc && prev_cyc == cyc - 1 && prev_wr && last_mapped
			&& last_slave == prev_slave)
		begin
			bp_hits++;
			assert (o_stall) else report_mismatch("o_stall", o_stall, 1);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Request side
	////////////////////////////////////////////////////////////

	task automatic new_request();
		logic [31:0] r;
		r = $random(seed);
		i_req.addr  = r[7:0];
		i_req.sel   = r[11:8];
		i_req.we    = r[12];
		i_req.wdata = $random(seed);
		i_valid     = 1'b1;
		holding     = 1'b1;
	endtask

	// Accepted at the next rising edge, so the model updates now
	task automatic accept_request();
		exp_rsp_t	e;
		int		slot;
		logic		mapped;
		slot   = i_req.addr;
		mapped = (slot < MAP_WORDS);
		e.err      = !mapped;
		e.rd       = mapped && !i_req.we;
		e.isolated = (exp_q.size() == 0);
		e.data     = '0;
		e.cyc      = cyc + 1;
		if (mapped && i_req.we)
		begin
			for (int b = 0; b < `WBFAB_SELW; b++)
				if (i_req.sel[b])
					model_mem[slot][8*b +: 8] = i_req.wdata[8*b +: 8];
		end
		else if (mapped)
			e.data = model_mem[slot];
		if (e.isolated)
			iso_hits++;
		exp_q.push_back(e);
		prev_cyc    = last_cyc;
		prev_slave  = last_slave;
		prev_wr     = last_wr;
		last_cyc    = cyc + 1;
		last_slave  = slot / `WBFAB_MEM_WORDS;
		last_mapped = mapped;
		last_wr     = mapped && i_req.we;
	endtask

	initial
	begin
		logic [31:0]	gap;
		int		drain;
		seed    = 32'hc9eb_fb7b;
		i_reset = 1'b1;
		i_valid = 1'b0;
		i_req   = '0;
		holding = 1'b0;
		// Slaves clear on reset, so the model starts at zero too
		for (int w = 0; w < MAP_WORDS; w++)
			model_mem[w] = '0;
		repeat (3) @(posedge i_clk);
		@(negedge i_clk);
		i_reset = 1'b0;

		while (sent < N_REQ || holding)
		begin
			@(negedge i_clk);
			check_response();
			check_back_pressure();
			if (!holding)
			begin
				// About one idle cycle in four
				gap = $random(seed);
				if (sent < N_REQ && gap[1:0] != 2'b00)
					new_request();
				else
					i_valid = 1'b0;
			end
			// Stall is registered, so it is settled here
			if (holding && !o_stall)
			begin
				accept_request();
				holding = 1'b0;
				sent++;
			end
		end

		// Bounded drain, a lost response leaves the count short
		drain = 0;
		while (exp_q.size() != 0 && drain < DRAIN_CYCLES)
		begin
			@(negedge i_clk);
			i_valid = 1'b0;
			check_response();
			check_back_pressure();
			drain++;
		end

		// Idle tail, a stray response here has no request behind it
		repeat (4)
		begin
			@(negedge i_clk);
			i_valid = 1'b0;
			check_response();
		end
		assert (rsp_count == sent) else report_mismatch("response count", rsp_count, sent);
		assert (bp_hits > 0)
		else
		begin
			$display("Error: the random run never stalled behind a write");
			abort_run();
		end
		assert (iso_hits > 0)
		else
		begin
			$display("Error: the random run had no isolated request");
			abort_run();
		end
		if (i_wb_slave_fabric.i_protocol_asserts.fail_count == 0)
		begin
			$display("Done: no errors");
			$finish;
		end
		else
		begin
			$display("Error: %0d protocol assertion failures",
				i_wb_slave_fabric.i_protocol_asserts.fail_count);
			abort_run();
		end
	end

	// Hang guard
	initial
	begin
		#(WATCHDOG_NS);
		$display("Error at %0t ns: watchdog expired, the DUT stopped answering", $time);
		abort_run();
	end

endmodule

/* hw/scratch_ram_port.sv */
// Scratch memory slave with byte selects
// Reads ack one cycle after acceptance; writes also go busy for a cycle

`timescale 1ns/1ps
`default_nettype none

`include "wbfab_macros.svh"

module scratch_ram_port (
	input  logic			i_clk,
	input  logic			i_reset,
	input  logic			i_sel,
	input  logic			i_valid,
	input  wbfab_pkg::wb_req_t	i_req,
	output logic			o_busy,
	output wbfab_pkg::wb_rsp_t	o_rsp
);

	logic [`WBFAB_DW-1:0]	mem [0:`WBFAB_MEM_WORDS-1];
	logic [`WBFAB_IDXW-1:0]	idx;
	logic			accept;
	logic			ack_q;
	logic [`WBFAB_DW-1:0]	rdata_q;

	// Low address bits pick the word
	assign idx = i_req.addr[`WBFAB_IDXW-1:0];

	// Busy slave refuses the request, the decoder holds it
	assign accept = i_sel && i_valid && !o_busy;

	////////////////////////////////////////////////////////////
	// Memory array
	////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			// Cleared so never written words read back as zero
			for (int w = 0; w < `WBFAB_MEM_WORDS; w++)
				mem[w] <= '0;
		end
		else if (accept && i_req.we)
		begin
			// Only the enabled byte lanes change
			for (int b = 0; b < `WBFAB_SELW; b++)
				if (i_req.sel[b])
					mem[idx][8*b +: 8] <= i_req.wdata[8*b +: 8];
		end
	end

	// Ack and write busy, both one cycle pulses
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			ack_q  <= 1'b0;
			o_busy <= 1'b0;
		end
		else
		begin
			ack_q  <= accept;
			o_busy <= accept && i_req.we;
		end
	end

	// Read word captured at acceptance
	always_ff @(posedge i_clk)
	begin
		if (accept && !i_req.we)
			rdata_q <= mem[idx];
	end

	assign o_rsp = '{ack: ack_q, rdata: rdata_q};

endmodule

`default_nettype wire

/* hw/wb_addr_decode.sv */
// Registered address decoder for the pipelined Wishbone fabric
// Produces a one-hot slave select plus an unmapped bit, and holds
// the registered request while the selected slave stalls

`timescale 1ns/1ps
`default_nettype none

`include "wbfab_macros.svh"

module wb_addr_decode (
	input  logic				i_clk,
	input  logic				i_reset,
	// Master side
	input  logic				i_valid,
	input  wbfab_pkg::wb_req_t		i_req,
	output logic				o_stall,
	// Slave side
	output logic				o_valid,
	input  logic				i_stall,
	output logic [`WBFAB_NS:0]		o_decode,
	output wbfab_pkg::wb_req_t		o_req
);

	// Only the slave naming bits take part in the compare
	localparam logic [`WBFAB_AW-1:0] ADDR_MASK = `WBFAB_ADDR_MASK;

	logic [`WBFAB_NS:0]	request;

	////////////////////////////////////////////////////////////
	// Combinational decode
	////////////////////////////////////////////////////////////

	always_comb
	begin : decode_comb
		logic			none_sel;
		logic [`WBFAB_AW-1:0]	slave_base;

		// Assume no slave matches until one proves otherwise
		none_sel = 1'b1;
		for (int k = 0; k < `WBFAB_NS; k++)
		begin
			// Base of slave k has k in its top bits
			slave_base = '0;
			slave_base[`WBFAB_AW-1 -: `WBFAB_SLAVE_BITS] =
				k[`WBFAB_SLAVE_BITS-1:0];
			request[k] = i_valid
				&& (((i_req.addr ^ slave_base) & ADDR_MASK) == '0);
			if (request[k])
				none_sel = 1'b0;
		end
		// Extra bit flags a request that will end in a bus error
		request[`WBFAB_NS] = i_valid && none_sel;
	end

	////////////////////////////////////////////////////////////
	// Output register
	////////////////////////////////////////////////////////////

	// Stall only when something is actually held
	assign o_stall = o_valid && i_stall;

	// Valid advances whenever the held entry is consumed
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_valid <= 1'b0;
		else if (!o_stall)
			o_valid <= i_valid;
	end

	// Decode follows valid, zero whenever nothing is requested
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_decode <= '0;
		else if (!o_stall)
			o_decode <= request;
	end

	// Request payload, held stable while stalled
	always_ff @(posedge i_clk)
	begin
		if (!o_stall)
			o_req <= i_req;
	end

endmodule

`default_nettype wire

/* hw/wb_resp_merge.sv */
// Response merger for the Wishbone slave fabric
// Routes slave busy back as stall, folds slave acks into one response,
// and turns unmapped requests into a bus error pulse

`timescale 1ns/1ps
`default_nettype none

`include "wbfab_macros.svh"

module wb_resp_merge (
	input  logic			i_clk,
	input  logic			i_reset,
	// Held decoder entry
	input  logic			i_valid,
	input  logic [`WBFAB_NS:0]	i_decode,
	// Slave side
	input  logic [`WBFAB_NS-1:0]	i_busy,
	input  wbfab_pkg::wb_rsp_t	i_rsp [0:`WBFAB_NS-1],
	// Back to the decoder and the master
	output logic			o_stall,
	output logic			o_ack,
	output logic			o_err,
	output logic [`WBFAB_DW-1:0]	o_rdata
);

	////////////////////////////////////////////////////////////
	// Stall routing
	////////////////////////////////////////////////////////////

	// Busy of the selected slave only, unmapped never stalls
	always_comb
	begin
		o_stall = 1'b0;
		for (int k = 0; k < `WBFAB_NS; k++)
			if (i_decode[k])
				o_stall = i_valid && i_busy[k];
	end

	// Unmapped entry is consumed at once, error one cycle later
	// so it lines up with a slave ack
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_err <= 1'b0;
		else
			o_err <= i_valid && i_decode[`WBFAB_NS];
	end

	////////////////////////////////////////////////////////////
	// Ack and read data merge
	////////////////////////////////////////////////////////////

	// One slave acks at a time, so an OR of masked data is enough
	always_comb
	begin
		o_ack   = 1'b0;
		o_rdata = '0;
		for (int k = 0; k < `WBFAB_NS; k++)
		begin
			o_ack = o_ack | i_rsp[k].ack;
			if (i_rsp[k].ack)
				o_rdata = o_rdata | i_rsp[k].rdata;
		end
	end

endmodule

`default_nettype wire

/* hw/wb_slave_fabric.sv */
// Top of the Wishbone slave fabric
// Decoder in front of four scratch memories, responses merged behind them

`timescale 1ns/1ps
`default_nettype none

`include "wbfab_macros.svh"

module wb_slave_fabric (
	input  logic			i_clk,
	input  logic			i_reset,
	input  logic			i_valid,
	input  wbfab_pkg::wb_req_t	i_req,
	output logic			o_stall,
	output logic			o_ack,
	output logic			o_err,
	output logic [`WBFAB_DW-1:0]	o_rdata
);

	// Registered decoder outputs
	logic			dec_valid;
	logic [`WBFAB_NS:0]	dec_decode;
	wbfab_pkg::wb_req_t	dec_req;
	// Stall from the merger into the decoder
	logic			dec_stall;
	// Per slave status
	logic [`WBFAB_NS-1:0]	slave_busy;
	wbfab_pkg::wb_rsp_t	slave_rsp [0:`WBFAB_NS-1];

	wb_addr_decode i_addr_decode (
		.i_clk    (i_clk),
		.i_reset  (i_reset),
		.i_valid  (i_valid),
		.i_req    (i_req),
		.o_stall  (o_stall),
		.o_valid  (dec_valid),
		.i_stall  (dec_stall),
		.o_decode (dec_decode),
		.o_req    (dec_req)
	);

	// One scratch memory per decode bit, unmapped bit left to the merger
	for (genvar k = 0; k < `WBFAB_NS; k++)
	begin : g_slave
		scratch_ram_port i_ram (
			.i_clk   (i_clk),
			.i_reset (i_reset),
			.i_sel   (dec_decode[k]),
			.i_valid (dec_valid),
			.i_req   (dec_req),
			.o_busy  (slave_busy[k]),
			.o_rsp   (slave_rsp[k])
		);
	end

	wb_resp_merge i_resp_merge (
		.i_clk    (i_clk),
		.i_reset  (i_reset),
		.i_valid  (dec_valid),
		.i_decode (dec_decode),
		.i_busy   (slave_busy),
		.i_rsp    (slave_rsp),
		.o_stall  (dec_stall),
		.o_ack    (o_ack),
		.o_err    (o_err),
		.o_rdata  (o_rdata)
	);

endmodule

`default_nettype wire

/* hw/wbfab_macros.svh */
// Widths, slave count and memory map of the Wishbone slave fabric
// Slave k owns the 32 words whose top three address bits equal k

`ifndef WBFAB_MACROS_SVH
`define WBFAB_MACROS_SVH

// Word address width
`define WBFAB_AW		8
// Data bus width
`define WBFAB_DW		32
// One select bit per data byte
`define WBFAB_SELW		4
// Number of scratch memory slaves
`define WBFAB_NS		4
// Word index inside one slave
`define WBFAB_IDXW		5
// Top address bits that name a slave
`define WBFAB_SLAVE_BITS	3
// Words held by each slave
`define WBFAB_MEM_WORDS		(1 << `WBFAB_IDXW)
// Compare mask over the slave naming bits
`define WBFAB_ADDR_MASK		{{`WBFAB_SLAVE_BITS{1'b1}}, {`WBFAB_IDXW{1'b0}}}

`endif

/* hw/wbfab_pkg.sv */
// Shared types for the Wishbone slave fabric
// One master request and one slave response, as packed structs

`include "wbfab_macros.svh"

package wbfab_pkg;

	////////////////////////////////////////////////////////////
	// Request from the master side
	////////////////////////////////////////////////////////////

	// Travels from the master through the decoder to every slave
	typedef struct packed {
		// High for a write, low for a read
		logic				we;
		// Word address
		logic [`WBFAB_AW-1:0]		addr;
		// Write data, ignored on reads
		logic [`WBFAB_DW-1:0]		wdata;
		// Byte lane enables for writes
		logic [`WBFAB_SELW-1:0]	sel;
	} wb_req_t;

	////////////////////////////////////////////////////////////
	// Response from one slave
	////////////////////////////////////////////////////////////

	// Ack is a single cycle pulse, no back-pressure on responses
	typedef struct packed {
		logic				ack;
		// Only meaningful in the ack cycle of a read
		logic [`WBFAB_DW-1:0]		rdata;
	} wb_rsp_t;

endpackage

/* sources.f */
+incdir+hw
hw/wbfab_pkg.sv
hw/wb_addr_decode.sv
hw/scratch_ram_port.sv
hw/wb_resp_merge.sv
hw/wb_slave_fabric.sv
dv/wb_slave_fabric_asserts.sv
dv/wb_slave_fabric_tb.sv
